/* nts_api_decode.sv */
/*
 * API address decoder.
 * Block selects, request broadcast and the registered read response.
 */
`include "nts_consts.svh"

module nts_api_decode (
  input  logic                    i_clk,
  input  logic                    i_areset,
  input  logic                    i_api_cs,
  input  logic                    i_api_we,
  input  nts_api_pkg::api_addr_t  i_api_address,
  input  nts_api_pkg::api_data_t  i_api_write_data,
  input  nts_api_pkg::api_data_t  i_engine_rdata,
  input  nts_api_pkg::api_data_t  i_debug_rdata,
  output nts_api_pkg::api_req_t   o_req,
  output logic                    o_engine_cs,
  output logic                    o_debug_cs,
  output nts_api_pkg::api_data_t  o_api_read_data,
  output logic                    o_api_read_data_valid
);

  logic [3:0]             block;
  logic                   rd_req;
  nts_api_pkg::api_data_t read_data_reg;
  logic                   read_valid_reg;

  // ----------------------------------------------------------
  // Block select
  // ----------------------------------------------------------
  assign block       = i_api_address[11:8];
  assign o_engine_cs = i_api_cs && (block == `NTS_BLOCK_ENGINE);
  assign o_debug_cs  = i_api_cs && (block == `NTS_BLOCK_DEBUG);
  assign rd_req      = i_api_cs && !i_api_we; // Any block, mapped or not

  always_comb
  begin
    o_req.we         = i_api_we;
    o_req.offset     = i_api_address[7:0];
    o_req.write_data = i_api_write_data;
  end

  // ----------------------------------------------------------
  // Read response, one cycle after the request
  // ----------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      read_valid_reg <= 1'b0;
    else
      read_valid_reg <= rd_req;
  end

  // Blocks drive zero when not selected, so an OR is enough
  always_ff @(posedge i_clk)
  begin
    if (rd_req)
      read_data_reg <= i_engine_rdata | i_debug_rdata;
  end

  assign o_api_read_data       = read_data_reg;
  assign o_api_read_data_valid = read_valid_reg;

  // An unselected block must return zero for the OR above to hold
  a_unselected_zero : assert property (
    @(posedge i_clk) disable iff (i_areset)
    (o_engine_cs || i_engine_rdata == '0) && (o_debug_cs || i_debug_rdata == '0)
  );

endmodule

/* nts_api_pkg.sv */
/*
 * Register API types.
 * External address, block offset, data word and the internal request.
 */
package nts_api_pkg;

  typedef logic [11:0] api_addr_t;   // External address, block in 11..8
  typedef logic [7:0]  api_offset_t; // Register offset inside a block
  typedef logic [31:0] api_data_t;

  // Request broadcast from the decoder to every block
  typedef struct packed {
    logic        we;
    api_offset_t offset;
    api_data_t   write_data;
  } api_req_t;

endpackage

/* nts_consts.svh */
/*
 * Constants of the NTS engine register map.
 * Identification words, block numbers, register offsets, tick reset value.
 */
`ifndef NTS_CONSTS_SVH
`define NTS_CONSTS_SVH

// ----------------------------------------------------------
// Identification words
// ----------------------------------------------------------
`define NTS_CORE_NAME0   32'h4e_54_53_5f // "NTS_"
`define NTS_CORE_NAME1   32'h45_4e_47_4e // "ENGN"
`define NTS_CORE_VERSION 32'h30_2e_30_36 // "0.06"
`define NTS_DEBUG_NAME   32'h44_42_55_47 // "DBUG"

// Block numbers, address bits 11..8
`define NTS_BLOCK_ENGINE 4'd0
`define NTS_BLOCK_DEBUG  4'd1

// ----------------------------------------------------------
// Engine block offsets
// ----------------------------------------------------------
`define NTS_ADDR_NAME0   8'h00
`define NTS_ADDR_NAME1   8'h01
`define NTS_ADDR_VERSION 8'h02
`define NTS_ADDR_CTRL    8'h08
`define NTS_ADDR_STATUS  8'h09

// Debug block offsets, counters take an even/odd pair
`define NTS_ADDR_DBG_PROCESSED  8'h00
`define NTS_ADDR_DBG_BAD_COOKIE 8'h02
`define NTS_ADDR_DBG_BAD_AUTH   8'h04
`define NTS_ADDR_DBG_BAD_KEYID  8'h06
`define NTS_ADDR_DBG_NAME       8'h08
`define NTS_ADDR_DBG_SYSTICK    8'h09
`define NTS_ADDR_DBG_ERR_CRYPTO 8'h20
`define NTS_ADDR_DBG_ERR_TXBUF  8'h22

`define NTS_SYSTICK_RESET 32'd1

`endif

/* nts_counter64.sv */
/*
 * 64-bit event counter.
 * Low half is held on a sample so both halves read as one value.
 */
module nts_counter64 (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_inc,
  input  logic                      i_lsb_sample,
  output nts_stats_pkg::stat_half_t o_msb,
  output nts_stats_pkg::stat_half_t o_lsb
);

  nts_stats_pkg::stat_count_t count_reg;
  nts_stats_pkg::stat_half_t  lsb_hold_reg;

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      count_reg    <= '0;
      lsb_hold_reg <= '0;
    end
    else
    begin
      if (i_inc)
        count_reg <= count_reg + 64'd1;
      if (i_lsb_sample)
        lsb_hold_reg <= count_reg[31:0]; // Same value as the high half read now
    end
  end

  assign o_msb = count_reg[63:32];
  assign o_lsb = lsb_hold_reg;

  // Counter is monotonic outside reset
  a_count_monotonic : assert property (
    @(posedge i_clk) disable iff (i_areset) count_reg >= $past(count_reg)
  );

endmodule

/* nts_debug_stats.sv */
/*
 * Debug register block.
 * Six 64-bit event counters, free-running tick and the debug read map.
 */
`include "nts_consts.svh"

module nts_debug_stats (
  input  logic                        i_clk,
  input  logic                        i_areset,
  input  logic                        i_cs,
  input  nts_api_pkg::api_req_t       i_req,
  input  nts_stats_pkg::stat_events_t i_events,
  output nts_api_pkg::api_data_t      o_rdata
);

  // Counter slots
  localparam int CNT_PROCESSED  = 0;
  localparam int CNT_BAD_COOKIE = 1;
  localparam int CNT_BAD_AUTH   = 2;
  localparam int CNT_BAD_KEYID  = 3;
  localparam int CNT_ERR_CRYPTO = 4;
  localparam int CNT_ERR_TXBUF  = 5;
  localparam int NUM_COUNTERS   = 6;

  logic [NUM_COUNTERS-1:0]   inc;
  logic [NUM_COUNTERS-1:0]   lsb_sample;
  nts_stats_pkg::stat_half_t cnt_msb [NUM_COUNTERS];
  nts_stats_pkg::stat_half_t cnt_lsb [NUM_COUNTERS];
  nts_stats_pkg::stat_half_t systick_reg;
  logic                      rd;

  // ----------------------------------------------------------
  // Event counters
  // ----------------------------------------------------------
  always_comb
  begin
    inc                 = '0;
    inc[CNT_PROCESSED]  = i_events.processed;
    inc[CNT_BAD_COOKIE] = i_events.bad_cookie;
    inc[CNT_BAD_AUTH]   = i_events.bad_auth;
    inc[CNT_BAD_KEYID]  = i_events.bad_keyid;
    inc[CNT_ERR_CRYPTO] = i_events.error_crypto;
    inc[CNT_ERR_TXBUF]  = i_events.error_txbuf;
  end

  for (genvar i = 0; i < NUM_COUNTERS; i++)
  begin : g_cnt
    nts_counter64 u_counter (
      .i_clk        (i_clk),
      .i_areset     (i_areset),
      .i_inc        (inc[i]),
      .i_lsb_sample (lsb_sample[i]),
      .o_msb        (cnt_msb[i]),
      .o_lsb        (cnt_lsb[i])
    );
  end

  // System tick, wraps freely
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      systick_reg <= `NTS_SYSTICK_RESET;
    else
      systick_reg <= systick_reg + 32'd1;
  end

  // ----------------------------------------------------------
  // Read map, writes are ignored
  // ----------------------------------------------------------
  assign rd = i_cs && !i_req.we;

  always_comb
  begin
    o_rdata    = '0;
    lsb_sample = '0;
    if (rd)
    begin
      case (i_req.offset)
        `NTS_ADDR_DBG_PROCESSED:
        begin
          o_rdata                   = cnt_msb[CNT_PROCESSED];
          lsb_sample[CNT_PROCESSED] = 1'b1;
        end
        `NTS_ADDR_DBG_PROCESSED + 8'd1:  o_rdata = cnt_lsb[CNT_PROCESSED];
        `NTS_ADDR_DBG_BAD_COOKIE:
        begin
          o_rdata                    = cnt_msb[CNT_BAD_COOKIE];
          lsb_sample[CNT_BAD_COOKIE] = 1'b1;
        end
        `NTS_ADDR_DBG_BAD_COOKIE + 8'd1: o_rdata = cnt_lsb[CNT_BAD_COOKIE];
        `NTS_ADDR_DBG_BAD_AUTH:
        begin
          o_rdata                  = cnt_msb[CNT_BAD_AUTH];
          lsb_sample[CNT_BAD_AUTH] = 1'b1;
        end
        `NTS_ADDR_DBG_BAD_AUTH + 8'd1:   o_rdata = cnt_lsb[CNT_BAD_AUTH];
        `NTS_ADDR_DBG_BAD_KEYID:
        begin
          o_rdata                   = cnt_msb[CNT_BAD_KEYID];
          lsb_sample[CNT_BAD_KEYID] = 1'b1;
        end
        `NTS_ADDR_DBG_BAD_KEYID + 8'd1:  o_rdata = cnt_lsb[CNT_BAD_KEYID];
        `NTS_ADDR_DBG_NAME:              o_rdata = `NTS_DEBUG_NAME;
        `NTS_ADDR_DBG_SYSTICK:           o_rdata = systick_reg;
        `NTS_ADDR_DBG_ERR_CRYPTO:
        begin
          o_rdata                    = cnt_msb[CNT_ERR_CRYPTO];
          lsb_sample[CNT_ERR_CRYPTO] = 1'b1;
        end
        `NTS_ADDR_DBG_ERR_CRYPTO + 8'd1: o_rdata = cnt_lsb[CNT_ERR_CRYPTO];
        `NTS_ADDR_DBG_ERR_TXBUF:
        begin
          o_rdata                   = cnt_msb[CNT_ERR_TXBUF];
          lsb_sample[CNT_ERR_TXBUF] = 1'b1;
        end
        `NTS_ADDR_DBG_ERR_TXBUF + 8'd1:  o_rdata = cnt_lsb[CNT_ERR_TXBUF];
        default:                         o_rdata = '0;
      endcase
    end
  end

endmodule

/* nts_engine_regs.sv */
/*
 * Engine register block.
 * Identification words, control enable, status and engine busy.
 */
`include "nts_consts.svh"

module nts_engine_regs (
  input  logic                   i_clk,
  input  logic                   i_areset,
  input  logic                   i_cs,
  input  nts_api_pkg::api_req_t  i_req,
  input  logic                   i_parser_busy,
  output nts_api_pkg::api_data_t o_rdata,
  output logic                   o_busy
);

  logic ctrl_reg; // Engine enable
  logic ctrl_we;

  assign ctrl_we = i_cs && i_req.we && (i_req.offset == `NTS_ADDR_CTRL);

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      ctrl_reg <= 1'b0;
    else if (ctrl_we)
      ctrl_reg <= i_req.write_data[0];
  end

  // Disabled engine counts as busy
  assign o_busy = !ctrl_reg || i_parser_busy;

  // ----------------------------------------------------------
  // Read map
  // ----------------------------------------------------------
  always_comb
  begin
    o_rdata = '0;
    if (i_cs && !i_req.we)
    begin
      case (i_req.offset)
        `NTS_ADDR_NAME0:   o_rdata = `NTS_CORE_NAME0;
        `NTS_ADDR_NAME1:   o_rdata = `NTS_CORE_NAME1;
        `NTS_ADDR_VERSION: o_rdata = `NTS_CORE_VERSION;
        `NTS_ADDR_CTRL:    o_rdata = {31'd0, ctrl_reg};
        `NTS_ADDR_STATUS:  o_rdata = {31'd0, !i_parser_busy}; // Bit 0 is parser idle
        default:           o_rdata = '0;
      endcase
    end
  end

endmodule

/* nts_engine_top.f */
+incdir+.
nts_api_pkg.sv
nts_stats_pkg.sv
nts_counter64.sv
nts_api_decode.sv
nts_engine_regs.sv
nts_debug_stats.sv
nts_engine_top.sv
tb_nts_engine.sv

/* nts_engine_top.sv */
/*
 * NTS engine register top.
 * Address decoder with the engine and debug register blocks.
 */
module nts_engine_top (
  input  logic                        i_clk,
  input  logic                        i_areset,
  input  logic                        i_api_cs,
  input  logic                        i_api_we,
  input  nts_api_pkg::api_addr_t      i_api_address,
  input  nts_api_pkg::api_data_t      i_api_write_data,
  input  logic                        i_parser_busy,
  input  nts_stats_pkg::stat_events_t i_events,
  output nts_api_pkg::api_data_t      o_api_read_data,
  output logic                        o_api_read_data_valid,
  output logic                        o_busy
);

  nts_api_pkg::api_req_t  req;
  logic                   engine_cs;
  logic                   debug_cs;
  nts_api_pkg::api_data_t engine_rdata;
  nts_api_pkg::api_data_t debug_rdata;

  nts_api_decode u_decode (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_api_cs              (i_api_cs),
    .i_api_we              (i_api_we),
    .i_api_address         (i_api_address),
    .i_api_write_data      (i_api_write_data),
    .i_engine_rdata        (engine_rdata),
    .i_debug_rdata         (debug_rdata),
    .o_req                 (req),
    .o_engine_cs           (engine_cs),
    .o_debug_cs            (debug_cs),
    .o_api_read_data       (o_api_read_data),
    .o_api_read_data_valid (o_api_read_data_valid)
  );

  nts_engine_regs u_engine (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_cs          (engine_cs),
    .i_req         (req),
    .i_parser_busy (i_parser_busy),
    .o_rdata       (engine_rdata),
    .o_busy        (o_busy)
  );

  nts_debug_stats u_debug (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_cs     (debug_cs),
    .i_req    (req),
    .i_events (i_events),
    .o_rdata  (debug_rdata)
  );

endmodule

/* nts_stats_pkg.sv */
/*
 * Statistics types.
 * Counter widths and the event strobe bundle from the parser.
 */
package nts_stats_pkg;

  typedef logic [31:0] stat_half_t;  // One half as seen on the API
  typedef logic [63:0] stat_count_t;

  // One-cycle event strobes
  typedef struct packed {
    logic processed;
    logic bad_cookie;
    logic bad_auth;
    logic bad_keyid;
    logic error_crypto;
    logic error_txbuf;
  } stat_events_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the NTS engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f nts_engine_top.f \
  --top-module tb_nts_engine \
  -Mdir obj_dir -o sim_nts_engine

./obj_dir/sim_nts_engine > sim.log
cat sim.log

if grep -q -F '** PASS **' sim.log; then
  exit 0
else
  exit 1
fi

/* tb_nts_engine.sv */
/*
 * Directed testbench for the NTS engine register top.
 * Clock and reset, API read/write and event tasks, value check and tests.
 */
`include "nts_consts.svh"

module tb_nts_engine;

  timeunit 1ns;
  timeprecision 100ps;

  logic                        clk;
  logic                        areset;
  logic                        api_cs;
  logic                        api_we;
  nts_api_pkg::api_addr_t      api_address;
  nts_api_pkg::api_data_t      api_write_data;
  logic                        parser_busy;
  nts_stats_pkg::stat_events_t events;
  nts_api_pkg::api_data_t      api_read_data;
  logic                        api_read_data_valid;
  logic                        busy;

  int                          error_count;
  int                          check_count;
  nts_stats_pkg::stat_count_t  exp_count [6]; // Reference event totals

  localparam int READ_TIMEOUT = 16; // Cycles to wait for a read valid

  nts_engine_top i_dut (
    .i_clk                 (clk),
    .i_areset              (areset),
    .i_api_cs              (api_cs),
    .i_api_we              (api_we),
    .i_api_address         (api_address),
    .i_api_write_data      (api_write_data),
    .i_parser_busy         (parser_busy),
    .i_events              (events),
    .o_api_read_data       (api_read_data),
    .o_api_read_data_valid (api_read_data_valid),
    .o_busy                (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic api_write(input nts_api_pkg::api_addr_t addr, input nts_api_pkg::api_data_t data);
    @(posedge clk);
    api_cs         <= 1'b1;
    api_we         <= 1'b1;
    api_address    <= addr;
    api_write_data <= data;
    @(posedge clk);
    api_cs <= 1'b0;
    api_we <= 1'b0;
    @(negedge clk);
    check_value("write gives no valid", 32'd0, {31'd0, api_read_data_valid});
  endtask

  task automatic api_read(input nts_api_pkg::api_addr_t addr, output nts_api_pkg::api_data_t data);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    data   = '0;
    @(posedge clk);
    api_cs      <= 1'b1;
    api_we      <= 1'b0;
    api_address <= addr;
    @(posedge clk);
    api_cs <= 1'b0;
    while (!seen && waited < READ_TIMEOUT)
    begin
      @(negedge clk); // Outputs settled mid-cycle
      if (api_read_data_valid)
      begin
        seen = 1'b1;
        data = api_read_data;
      end
      waited++;
    end
    if (!seen)
    begin
      error_count++;
      $display("Read at address %h timed out without a read valid pulse", addr);
    end
    else
    begin
      // Valid comes in the cycle right after the request and lasts one cycle
      check_value("read valid latency", 32'd1, 32'(waited));
      @(negedge clk);
      check_value("read valid one cycle", 32'd0, {31'd0, api_read_data_valid});
    end
  endtask

  // Strobes on consecutive cycles, each one counted
  task automatic pulse_events(input nts_stats_pkg::stat_events_t mask, input int count);
    repeat (count)
    begin
      @(posedge clk);
      events <= mask;
    end
    @(posedge clk);
    events <= '0;
  endtask

  function automatic nts_stats_pkg::stat_events_t event_mask(input int idx);
    nts_stats_pkg::stat_events_t m;
    m = '0;
    case (idx)
      0: m.processed    = 1'b1;
      1: m.bad_cookie   = 1'b1;
      2: m.bad_auth     = 1'b1;
      3: m.bad_keyid    = 1'b1;
      4: m.error_crypto = 1'b1;
      default: m.error_txbuf = 1'b1;
    endcase
    return m;
  endfunction

  // Address of a counter's high half, low half is one above
  function automatic nts_api_pkg::api_addr_t counter_addr(input int idx);
    nts_api_pkg::api_offset_t off;
    case (idx)
      0: off = `NTS_ADDR_DBG_PROCESSED;
      1: off = `NTS_ADDR_DBG_BAD_COOKIE;
      2: off = `NTS_ADDR_DBG_BAD_AUTH;
      3: off = `NTS_ADDR_DBG_BAD_KEYID;
      4: off = `NTS_ADDR_DBG_ERR_CRYPTO;
      default: off = `NTS_ADDR_DBG_ERR_TXBUF;
    endcase
    return {`NTS_BLOCK_DEBUG, off};
  endfunction

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_reset_values();
    nts_api_pkg::api_data_t d;
    @(negedge clk);
    check_value("reset valid low", 32'd0, {31'd0, api_read_data_valid});
    check_value("reset busy", 32'd1, {31'd0, busy});
    api_read({`NTS_BLOCK_ENGINE, `NTS_ADDR_NAME0}, d);
    check_value("name0", 32'h4e54535f, d);
    api_read({`NTS_BLOCK_ENGINE, `NTS_ADDR_NAME1}, d);
    check_value("name1", 32'h454e474e, d);
    api_read({`NTS_BLOCK_ENGINE, `NTS_ADDR_VERSION}, d);
    check_value("version", 32'h302e3036, d);
    api_read({`NTS_BLOCK_DEBUG, `NTS_ADDR_DBG_NAME}, d);
    check_value("debug name", 32'h44425547, d);
    api_read({`NTS_BLOCK_ENGINE, `NTS_ADDR_CTRL}, d);
    check_value("reset ctrl", 32'd0, d);
  endtask

  task automatic test_control_busy();
    nts_api_pkg::api_data_t d;
    api_write({`NTS_BLOCK_ENGINE, `NTS_ADDR_CTRL}, 32'd1);
    api_read({`NTS_BLOCK_ENGINE, `NTS_ADDR_CTRL}, d);
    check_value("ctrl readback", 32'd1, d);
    @(posedge clk);
    parser_busy <= 1'b1;
    @(negedge clk);
    check_value("busy with parser busy", 32'd1, {31'd0, busy});
    api_read({`NTS_BLOCK_ENGINE, `NTS_ADDR_STATUS}, d);
    check_value("status with parser busy", 32'd0, d);
    @(posedge clk);
    parser_busy <= 1'b0;
    @(negedge clk);
    check_value("busy with parser idle", 32'd0, {31'd0, busy});
    api_read({`NTS_BLOCK_ENGINE, `NTS_ADDR_STATUS}, d);
    check_value("status with parser idle", 32'd1, d);
  endtask

  task automatic test_counters();
    nts_api_pkg::api_data_t d;
    int                     n;
    for (int i = 0; i < 6; i++)
    begin
      n = int'($urandom % 32'd20) + 1;
      pulse_events(event_mask(i), n);
      exp_count[i] = exp_count[i] + 64'(n);
      api_read(counter_addr(i), d);
      check_value("counter high", exp_count[i][63:32], d);
      api_read(counter_addr(i) + 12'd1, d);
      check_value("counter low", exp_count[i][31:0], d);
    end
  endtask

  task automatic test_low_capture();
    nts_api_pkg::api_data_t     d;
    nts_stats_pkg::stat_count_t held;
    int                         n;
    for (int i = 0; i < 6; i++)
    begin
      api_read(counter_addr(i), d);
      held = exp_count[i];   // Value at the high read
      n = int'($urandom % 32'd10) + 1;
      pulse_events(event_mask(i), n);
      exp_count[i] = exp_count[i] + 64'(n);
      api_read(counter_addr(i) + 12'd1, d);
      check_value("captured low", held[31:0], d);
      api_read(counter_addr(i), d);
      api_read(counter_addr(i) + 12'd1, d);
      check_value("low after new capture", exp_count[i][31:0], d);
    end
  endtask

  task automatic test_tick_unmapped();
    nts_api_pkg::api_data_t t1;
    nts_api_pkg::api_data_t t2;
    nts_api_pkg::api_data_t d;
    api_read({`NTS_BLOCK_DEBUG, `NTS_ADDR_DBG_SYSTICK}, t1);
    api_read({`NTS_BLOCK_DEBUG, `NTS_ADDR_DBG_SYSTICK}, t2);
    check_value("systick increasing", 32'd1, {31'd0, t2 > t1});
    api_read(12'h200, d); // No block 2
    check_value("unmapped block", 32'd0, d);
    api_read({`NTS_BLOCK_ENGINE, 8'h03}, d);
    check_value("unmapped engine offset", 32'd0, d);
    api_read({`NTS_BLOCK_DEBUG, 8'h0a}, d);
    check_value("unmapped debug offset", 32'd0, d);
  endtask

  initial
  begin
    error_count = 0;
    check_count = 0;
    for (int i = 0; i < 6; i++)
      exp_count[i] = '0;
    void'($urandom(32'h5fd0_87c5));
    areset         <= 1'b1;
    api_cs         <= 1'b0;
    api_we         <= 1'b0;
    api_address    <= '0;
    api_write_data <= '0;
    parser_busy    <= 1'b0;
    events         <= '0;
    repeat (4) @(posedge clk);
    areset <= 1'b0;

    test_reset_values();
    test_control_busy();
    test_counters();
    test_low_capture();
    test_tick_unmapped();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
